/* hw/fu_cdb.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_cdb (
    input  logic             clock,
    input  logic             reset,
    input  logic             alu_issue_valid,
    input  ooo_pkg::opcode_t alu_issue_op,
    input  ooo_pkg::data_t   alu_a,
    input  ooo_pkg::data_t   alu_b,
    input  ooo_pkg::prn_t    alu_prn,
    input  ooo_pkg::robn_t   alu_robn,
    input  logic             mult_issue_valid,
    input  ooo_pkg::data_t   mult_a,
    input  ooo_pkg::data_t   mult_b,
    input  ooo_pkg::prn_t    mult_prn,
    input  ooo_pkg::robn_t   mult_robn,
    output logic             alu_avail,
    output logic             mult_avail,
    output logic             cdb_valid,
    output ooo_pkg::prn_t    cdb_prn,
    output ooo_pkg::robn_t   cdb_robn,
    output ooo_pkg::data_t   cdb_value
);

    ooo_pkg::data_t alu_result;
    logic           alu_valid;
    ooo_pkg::data_t alu_out;
    ooo_pkg::prn_t  alu_out_prn;
    ooo_pkg::robn_t alu_out_robn;
    logic [ooo_pkg::mult_stages-1:0] m_valid;
    ooo_pkg::data_t m_prod [ooo_pkg::mult_stages];
    ooo_pkg::prn_t  m_prn  [ooo_pkg::mult_stages];
    ooo_pkg::robn_t m_robn [ooo_pkg::mult_stages];
    logic           mult_done;

    always_comb begin
        case (alu_issue_op)
            ooo_pkg::op_li:  alu_result = alu_b;
            ooo_pkg::op_add: alu_result = alu_a + alu_b;
            ooo_pkg::op_sub: alu_result = alu_a - alu_b;
            ooo_pkg::op_xor: alu_result = alu_a ^ alu_b;
            default:         alu_result = '0;
        endcase
    end

    assign mult_done  = m_valid[ooo_pkg::mult_stages-1];
    // the held ALU result drains whenever the multiplier is quiet
    assign alu_avail  = !alu_valid || !mult_done;
    assign mult_avail = 1'b1;

    // multiplier wins the bus
    assign cdb_valid = mult_done || alu_valid;
    assign cdb_prn   = mult_done ? m_prn[ooo_pkg::mult_stages-1] : alu_out_prn;
    assign cdb_robn  = mult_done ? m_robn[ooo_pkg::mult_stages-1] : alu_out_robn;
    assign cdb_value = mult_done ? m_prod[ooo_pkg::mult_stages-1] : alu_out;

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_valid <= 1'b0;
            m_valid   <= '0;
        end else begin
            if (alu_issue_valid) begin
                alu_valid <= 1'b1;
            end else if (!mult_done) begin
                alu_valid <= 1'b0;
            end
            m_valid <= {m_valid[ooo_pkg::mult_stages-2:0], mult_issue_valid};
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue_valid) begin
            alu_out      <= alu_result;
            alu_out_prn  <= alu_prn;
            alu_out_robn <= alu_robn;
        end
        // low word of the product
        m_prod[0] <= mult_a * mult_b;
        m_prn[0]  <= mult_prn;
        m_robn[0] <= mult_robn;
        for (int s = 1; s < ooo_pkg::mult_stages; s++) begin
            m_prod[s] <= m_prod[s-1];
            m_prn[s]  <= m_prn[s-1];
            m_robn[s] <= m_robn[s-1];
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        alu_issue_valid && alu_valid |-> !mult_done)
        else $error("ALU result overwritten before broadcast");

endmodule

`default_nettype wire

/* hw/ooo.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          dispatch_valid,
    input  ooo_pkg::opcode_t              dispatch_op,
    input  ooo_pkg::arn_t                 dispatch_dest,
    input  ooo_pkg::arn_t                 dispatch_src1,
    input  ooo_pkg::arn_t                 dispatch_src2,
    input  logic [ooo_pkg::imm_width-1:0] dispatch_imm,
    output logic                          structural_hazard,
    output logic                          commit_valid,
    output logic                          commit_wr_en,
    output ooo_pkg::arn_t                 commit_arn,
    output ooo_pkg::data_t                commit_value
);

    logic             dispatch_fire;
    ooo_pkg::prn_t    src1_prn;
    ooo_pkg::prn_t    src2_prn;
    ooo_pkg::prn_t    dest_prn;
    ooo_pkg::prn_t    told_prn;
    logic             free_empty;
    logic             free_valid;
    ooo_pkg::prn_t    free_prn;
    logic             read_valid1;
    logic             read_valid2;
    ooo_pkg::data_t   read_value1;
    ooo_pkg::data_t   read_value2;
    ooo_pkg::prn_t    commit_prn;
    logic             src1_zero;
    logic             src2_zero;
    logic             op1_ready;
    logic             op2_ready;
    ooo_pkg::data_t   op1;
    ooo_pkg::data_t   op2;
    logic             rs_full;
    logic             rob_full;
    ooo_pkg::robn_t   rob_tail;
    logic             alu_issue_valid;
    ooo_pkg::opcode_t alu_issue_op;
    ooo_pkg::data_t   alu_a;
    ooo_pkg::data_t   alu_b;
    ooo_pkg::prn_t    alu_prn;
    ooo_pkg::robn_t   alu_robn;
    logic             mult_issue_valid;
    ooo_pkg::data_t   mult_a;
    ooo_pkg::data_t   mult_b;
    ooo_pkg::prn_t    mult_prn;
    ooo_pkg::robn_t   mult_robn;
    logic             alu_avail;
    logic             mult_avail;
    logic             cdb_valid;
    ooo_pkg::prn_t    cdb_prn;
    ooo_pkg::robn_t   cdb_robn;
    ooo_pkg::data_t   cdb_value;

    // all three flags come straight from registers
    assign structural_hazard = rs_full || rob_full || free_empty;
    assign dispatch_fire     = dispatch_valid && !structural_hazard;

    // register 0 is always a ready zero
    assign src1_zero = dispatch_src1 == ooo_pkg::zero_reg;
    assign src2_zero = dispatch_src2 == ooo_pkg::zero_reg;
    assign op1_ready = src1_zero || read_valid1;
    assign op2_ready = src2_zero || read_valid2;
    assign op1       = src1_zero ? '0 : read_value1;
    assign op2       = src2_zero ? '0 : read_value2;

    assign commit_wr_en = commit_valid && commit_arn != ooo_pkg::zero_reg;

    rat rat_i (.*);

    prf prf_i (
        .*,
        .read_prn1(src1_prn),
        .read_prn2(src2_prn),
        .alloc_prn(dest_prn),
        .alloc_valid(dispatch_fire)
    );

    rs rs_i (
        .*,
        .op1_tag(src1_prn),
        .op2_tag(src2_prn),
        .robn(rob_tail)
    );

    fu_cdb fu_cdb_i (.*);

    rob rob_i (.*);

endmodule

`default_nettype wire

/* hw/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int arch_reg_sz = 8;
    localparam int phys_reg_sz = 24;
    localparam int rob_sz      = 8;
    localparam int rs_sz       = 4;
    localparam int data_width  = 32;
    // immediates are zero-extended to data_width
    localparam int imm_width   = 16;
    localparam int mult_stages = 3;

    typedef logic [$clog2(arch_reg_sz)-1:0] arn_t;
    typedef logic [$clog2(phys_reg_sz)-1:0] prn_t;
    typedef logic [$clog2(rob_sz)-1:0]      robn_t;
    typedef logic [data_width-1:0]          data_t;

    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_xor,
        op_mul
    } opcode_t;

    typedef enum logic {
        fu_alu,
        fu_mult
    } fu_class_t;

    // reads as zero, never written architecturally
    localparam arn_t zero_reg = '0;

endpackage

`default_nettype wire

/* hw/prf.sv */
`timescale 1ns/1ps
`default_nettype none

module prf (
    input  logic           clock,
    input  logic           reset,
    input  ooo_pkg::prn_t  read_prn1,
    input  ooo_pkg::prn_t  read_prn2,
    input  ooo_pkg::prn_t  alloc_prn,
    input  ooo_pkg::prn_t  commit_prn,
    input  logic           alloc_valid,
    input  logic           cdb_valid,
    input  ooo_pkg::prn_t  cdb_prn,
    input  ooo_pkg::data_t cdb_value,
    output logic           read_valid1,
    output logic           read_valid2,
    output ooo_pkg::data_t read_value1,
    output ooo_pkg::data_t read_value2,
    output ooo_pkg::data_t commit_value
);

    logic [ooo_pkg::phys_reg_sz-1:0] valid;
    ooo_pkg::data_t regs [ooo_pkg::phys_reg_sz];
    logic hit1;
    logic hit2;

    // a broadcast in the rename cycle is seen right away
    assign hit1         = cdb_valid && cdb_prn == read_prn1;
    assign hit2         = cdb_valid && cdb_prn == read_prn2;
    assign read_valid1  = valid[read_prn1] || hit1;
    assign read_valid2  = valid[read_prn2] || hit2;
    assign read_value1  = hit1 ? cdb_value : regs[read_prn1];
    assign read_value2  = hit2 ? cdb_value : regs[read_prn2];
    assign commit_value = regs[commit_prn];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::phys_reg_sz; i++) begin
                valid[i] <= i < ooo_pkg::arch_reg_sz;
            end
        end else begin
            if (cdb_valid) begin
                valid[cdb_prn] <= 1'b1;
            end
            if (alloc_valid) begin
                valid[alloc_prn] <= 1'b0;
            end
        end
    end

    // initial mapping holds zeros
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::arch_reg_sz; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb_valid) begin
            regs[cdb_prn] <= cdb_value;
        end
    end

    assert property (@(posedge clock) disable iff (reset) cdb_valid |-> !valid[cdb_prn])
        else $error("bus wrote a register that was already valid");

endmodule

`default_nettype wire

/* hw/rat.sv */
`timescale 1ns/1ps
`default_nettype none

module rat (
    input  logic          clock,
    input  logic          reset,
    input  logic          dispatch_fire,
    input  ooo_pkg::arn_t dispatch_dest,
    input  ooo_pkg::arn_t dispatch_src1,
    input  ooo_pkg::arn_t dispatch_src2,
    input  logic          free_valid,
    input  ooo_pkg::prn_t free_prn,
    output ooo_pkg::prn_t src1_prn,
    output ooo_pkg::prn_t src2_prn,
    output ooo_pkg::prn_t dest_prn,
    output ooo_pkg::prn_t told_prn,
    output logic          free_empty
);

    ooo_pkg::prn_t map_table [ooo_pkg::arch_reg_sz];
    // only the registers beyond the initial mapping circulate
    ooo_pkg::prn_t free_list [ooo_pkg::phys_reg_sz-ooo_pkg::arch_reg_sz];
    logic [$clog2(ooo_pkg::phys_reg_sz-ooo_pkg::arch_reg_sz)-1:0] fl_head;
    logic [$clog2(ooo_pkg::phys_reg_sz-ooo_pkg::arch_reg_sz)-1:0] fl_tail;
    logic [$clog2(ooo_pkg::phys_reg_sz-ooo_pkg::arch_reg_sz):0]   fl_count;
    logic dest_is_zero;

    assign dest_is_zero = dispatch_dest == ooo_pkg::zero_reg;
    assign src1_prn     = map_table[dispatch_src1];
    assign src2_prn     = map_table[dispatch_src2];
    assign dest_prn     = free_list[fl_head];
    // a discarded write returns its own register at retire
    assign told_prn     = dest_is_zero ? dest_prn : map_table[dispatch_dest];
    assign free_empty   = fl_count == '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::arch_reg_sz; i++) begin
                map_table[i] <= ooo_pkg::prn_t'(i);
            end
            for (int i = 0; i < ooo_pkg::phys_reg_sz - ooo_pkg::arch_reg_sz; i++) begin
                free_list[i] <= ooo_pkg::prn_t'(i + ooo_pkg::arch_reg_sz);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= ($bits(fl_count))'(ooo_pkg::phys_reg_sz - ooo_pkg::arch_reg_sz);
        end else begin
            if (dispatch_fire) begin
                fl_head <= fl_head + 1'b1;
                if (!dest_is_zero) begin
                    map_table[dispatch_dest] <= dest_prn;
                end
            end
            if (free_valid) begin
                free_list[fl_tail] <= free_prn;
                fl_tail            <= fl_tail + 1'b1;
            end
            case ({dispatch_fire, free_valid})
                2'b10:   fl_count <= fl_count - 1'b1;
                2'b01:   fl_count <= fl_count + 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (reset) dispatch_fire |-> !free_empty)
        else $error("rename popped an empty free list");

endmodule

`default_nettype wire

/* hw/rob.sv */
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  logic           clock,
    input  logic           reset,
    input  logic           dispatch_fire,
    input  ooo_pkg::arn_t  dispatch_dest,
    input  ooo_pkg::prn_t  dest_prn,
    input  ooo_pkg::prn_t  told_prn,
    input  logic           cdb_valid,
    input  ooo_pkg::robn_t cdb_robn,
    output logic           rob_full,
    output ooo_pkg::robn_t rob_tail,
    output logic           commit_valid,
    output ooo_pkg::arn_t  commit_arn,
    output ooo_pkg::prn_t  commit_prn,
    output logic           free_valid,
    output ooo_pkg::prn_t  free_prn
);

    ooo_pkg::arn_t  e_arn  [ooo_pkg::rob_sz];
    ooo_pkg::prn_t  e_prn  [ooo_pkg::rob_sz];
    ooo_pkg::prn_t  e_told [ooo_pkg::rob_sz];
    logic [ooo_pkg::rob_sz-1:0] used;
    logic [ooo_pkg::rob_sz-1:0] done;
    ooo_pkg::robn_t head;
    ooo_pkg::robn_t tail;
    logic [$clog2(ooo_pkg::rob_sz):0] count;

    assign rob_full     = count == ($bits(count))'(ooo_pkg::rob_sz);
    assign rob_tail     = tail;
    assign commit_valid = count != '0 && done[head];
    assign commit_arn   = e_arn[head];
    assign commit_prn   = e_prn[head];
    // previous mapping goes back to the free list
    assign free_valid   = commit_valid;
    assign free_prn     = e_told[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            used  <= '0;
            done  <= '0;
        end else begin
            if (cdb_valid) begin
                done[cdb_robn] <= 1'b1;
            end
            if (dispatch_fire) begin
                used[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (commit_valid) begin
                used[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            case ({dispatch_fire, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            e_arn[tail]  <= dispatch_dest;
            e_prn[tail]  <= dest_prn;
            e_told[tail] <= told_prn;
        end
    end

    assert property (@(posedge clock) disable iff (reset) commit_valid |-> used[head])
        else $error("retire from an empty reorder buffer slot");

    assert property (@(posedge clock) disable iff (reset) cdb_valid |-> used[cdb_robn])
        else $error("bus marked an empty reorder buffer slot");

endmodule

`default_nettype wire

/* hw/rs.sv */
`timescale 1ns/1ps
`default_nettype none

module rs (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          dispatch_fire,
    input  logic                          op1_ready,
    input  logic                          op2_ready,
    input  ooo_pkg::data_t                op1,
    input  ooo_pkg::data_t                op2,
    input  ooo_pkg::prn_t                 op1_tag,
    input  ooo_pkg::prn_t                 op2_tag,
    input  ooo_pkg::prn_t                 dest_prn,
    input  ooo_pkg::robn_t                robn,
    input  ooo_pkg::opcode_t              dispatch_op,
    input  logic [ooo_pkg::imm_width-1:0] dispatch_imm,
    input  logic                          cdb_valid,
    input  ooo_pkg::prn_t                 cdb_prn,
    input  ooo_pkg::data_t                cdb_value,
    input  logic                          alu_avail,
    input  logic                          mult_avail,
    output logic                          rs_full,
    output logic                          alu_issue_valid,
    output ooo_pkg::opcode_t              alu_issue_op,
    output ooo_pkg::data_t                alu_a,
    output ooo_pkg::data_t                alu_b,
    output ooo_pkg::prn_t                 alu_prn,
    output ooo_pkg::robn_t                alu_robn,
    output logic                          mult_issue_valid,
    output ooo_pkg::data_t                mult_a,
    output ooo_pkg::data_t                mult_b,
    output ooo_pkg::prn_t                 mult_prn,
    output ooo_pkg::robn_t                mult_robn
);

    logic [ooo_pkg::rs_sz-1:0] valid;
    logic [ooo_pkg::rs_sz-1:0] r1;
    logic [ooo_pkg::rs_sz-1:0] r2;
    ooo_pkg::data_t     e_op1   [ooo_pkg::rs_sz];
    ooo_pkg::data_t     e_op2   [ooo_pkg::rs_sz];
    ooo_pkg::prn_t      e_tag1  [ooo_pkg::rs_sz];
    ooo_pkg::prn_t      e_tag2  [ooo_pkg::rs_sz];
    ooo_pkg::prn_t      e_dest  [ooo_pkg::rs_sz];
    ooo_pkg::robn_t     e_robn  [ooo_pkg::rs_sz];
    ooo_pkg::opcode_t   e_op    [ooo_pkg::rs_sz];
    ooo_pkg::fu_class_t e_class [ooo_pkg::rs_sz];
    // older[j][i] means entry j was written before entry i
    logic [ooo_pkg::rs_sz-1:0] older [ooo_pkg::rs_sz];
    logic [ooo_pkg::rs_sz-1:0] ready;
    logic [ooo_pkg::rs_sz-1:0] oldest;
    logic [ooo_pkg::rs_sz-1:0] alu_pick;
    logic [ooo_pkg::rs_sz-1:0] mult_pick;
    logic [ooo_pkg::rs_sz-1:0] wr_sel;
    logic           is_li;
    logic           in_r1;
    logic           in_r2;
    ooo_pkg::data_t in_op1;
    ooo_pkg::data_t in_op2;

    assign rs_full = &valid;

    // oldest ready entry per unit class
    always_comb begin
        for (int i = 0; i < ooo_pkg::rs_sz; i++) begin
            ready[i] = valid[i] && r1[i] && r2[i];
        end
        for (int i = 0; i < ooo_pkg::rs_sz; i++) begin
            oldest[i] = ready[i];
            for (int j = 0; j < ooo_pkg::rs_sz; j++) begin
                if (ready[j] && older[j][i] && e_class[j] == e_class[i]) begin
                    oldest[i] = 1'b0;
                end
            end
            alu_pick[i]  = oldest[i] && alu_avail && e_class[i] == ooo_pkg::fu_alu;
            mult_pick[i] = oldest[i] && mult_avail && e_class[i] == ooo_pkg::fu_mult;
        end
    end

    always_comb begin
        alu_issue_valid  = |alu_pick;
        mult_issue_valid = |mult_pick;
        alu_issue_op     = ooo_pkg::op_li;
        alu_a            = '0;
        alu_b            = '0;
        alu_prn          = '0;
        alu_robn         = '0;
        mult_a           = '0;
        mult_b           = '0;
        mult_prn         = '0;
        mult_robn        = '0;
        for (int i = 0; i < ooo_pkg::rs_sz; i++) begin
            if (alu_pick[i]) begin
                alu_issue_op = e_op[i];
                alu_a        = e_op1[i];
                alu_b        = e_op2[i];
                alu_prn      = e_dest[i];
                alu_robn     = e_robn[i];
            end
            if (mult_pick[i]) begin
                mult_a    = e_op1[i];
                mult_b    = e_op2[i];
                mult_prn  = e_dest[i];
                mult_robn = e_robn[i];
            end
        end
    end

    // li takes the immediate as its second operand
    always_comb begin
        is_li  = dispatch_op == ooo_pkg::op_li;
        in_r1  = is_li || op1_ready || (cdb_valid && cdb_prn == op1_tag);
        in_r2  = is_li || op2_ready || (cdb_valid && cdb_prn == op2_tag);
        in_op1 = is_li ? '0 : (op1_ready ? op1 : cdb_value);
        in_op2 = is_li ? ooo_pkg::data_t'(dispatch_imm) : (op2_ready ? op2 : cdb_value);
        wr_sel = '0;
        for (int i = ooo_pkg::rs_sz - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                wr_sel    = '0;
                wr_sel[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~(alu_pick | mult_pick)) | (dispatch_fire ? wr_sel : '0);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < ooo_pkg::rs_sz; i++) begin
            if (cdb_valid && !r1[i] && e_tag1[i] == cdb_prn) begin
                r1[i]    <= 1'b1;
                e_op1[i] <= cdb_value;
            end
            if (cdb_valid && !r2[i] && e_tag2[i] == cdb_prn) begin
                r2[i]    <= 1'b1;
                e_op2[i] <= cdb_value;
            end
            if (dispatch_fire && wr_sel[i]) begin
                r1[i]      <= in_r1;
                r2[i]      <= in_r2;
                e_op1[i]   <= in_op1;
                e_op2[i]   <= in_op2;
                e_tag1[i]  <= op1_tag;
                e_tag2[i]  <= op2_tag;
                e_dest[i]  <= dest_prn;
                e_robn[i]  <= robn;
                e_op[i]    <= dispatch_op;
                e_class[i] <= dispatch_op == ooo_pkg::op_mul ? ooo_pkg::fu_mult : ooo_pkg::fu_alu;
                older[i]   <= '0;
                for (int j = 0; j < ooo_pkg::rs_sz; j++) begin
                    older[j][i] <= valid[j];
                end
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) dispatch_fire |-> !rs_full)
        else $error("reservation station written while full");

endmodule

`default_nettype wire

/* project.f */
hw/ooo_pkg.sv
hw/rat.sv
hw/prf.sv
hw/rs.sv
hw/fu_cdb.sv
hw/rob.sv
hw/ooo.sv
test/ooo_tb.sv

/* test/ooo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_tb;

    localparam int clock_period  = 100;
    localparam int reset_cycles  = 8;
    localparam int cycles_per_op = 20;
    localparam logic [31:0] lfsr_seed = 32'heeb4d780;

    typedef struct packed {
        logic           wr_en;
        ooo_pkg::arn_t  arn;
        ooo_pkg::data_t value;
    } commit_rec_t;

    logic                          clock;
    logic                          reset;
    logic                          dispatch_valid;
    ooo_pkg::opcode_t              dispatch_op;
    ooo_pkg::arn_t                 dispatch_dest;
    ooo_pkg::arn_t                 dispatch_src1;
    ooo_pkg::arn_t                 dispatch_src2;
    logic [ooo_pkg::imm_width-1:0] dispatch_imm;
    logic                          structural_hazard;
    logic                          commit_valid;
    logic                          commit_wr_en;
    ooo_pkg::arn_t                 commit_arn;
    ooo_pkg::data_t                commit_value;

    // architectural state in program order
    ooo_pkg::data_t arch_regs [ooo_pkg::arch_reg_sz];
    commit_rec_t    expected [$];
    int             dispatch_count;
    int             commit_count;
    int             hazard_holds;
    int             cycle_count;
    int             deadline = reset_cycles + 40;
    logic [31:0]    lfsr_state;

    ooo ooo_i (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // galois form, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hd000_0001 : lfsr_state >> 1;
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic ooo_pkg::data_t model_result(input ooo_pkg::opcode_t op,
                                                    input ooo_pkg::data_t a,
                                                    input ooo_pkg::data_t b,
                                                    input logic [15:0] imm);
        case (op)
            ooo_pkg::op_li:  return ooo_pkg::data_t'(imm);
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_xor: return a ^ b;
            ooo_pkg::op_mul: return a * b;
            default:         return '0;
        endcase
    endfunction

    // hold keeps the instruction on the inputs through a hazard
    task automatic send(input ooo_pkg::opcode_t op, input int dest, input int src1,
                        input int src2, input int imm, input bit hold);
        commit_rec_t    rec;
        ooo_pkg::data_t result;
        @(negedge clock);
        if (!hold) begin
            while (structural_hazard) begin
                dispatch_valid = 1'b0;
                @(negedge clock);
            end
        end
        dispatch_op    = op;
        dispatch_dest  = ooo_pkg::arn_t'(dest);
        dispatch_src1  = ooo_pkg::arn_t'(src1);
        dispatch_src2  = ooo_pkg::arn_t'(src2);
        dispatch_imm   = imm[15:0];
        dispatch_valid = 1'b1;
        while (structural_hazard) begin
            hazard_holds++;
            @(negedge clock);
        end
        result = model_result(op, arch_regs[src1], arch_regs[src2], imm[15:0]);
        rec.wr_en = dest != 0;
        rec.arn   = ooo_pkg::arn_t'(dest);
        rec.value = result;
        if (dest != 0) begin
            arch_regs[dest] = result;
        end
        expected.push_back(rec);
        dispatch_count++;
        deadline += cycles_per_op;
    endtask

    task automatic drain();
        @(negedge clock);
        dispatch_valid = 1'b0;
        while (expected.size() != 0) begin
            @(negedge clock);
        end
    endtask

    always @(negedge clock) begin : commit_monitor
        commit_rec_t rec;
        if (commit_valid === 1'b1) begin
            if (expected.size() == 0) begin
                stop_run("a commit arrived with no instruction outstanding");
            end else begin
                rec = expected.pop_front();
                commit_count++;
                assert (commit_arn == rec.arn)
                    else stop_run($sformatf("ERR %0t: commit_arn %0d, expected %0d",
                                            $time, commit_arn, rec.arn));
                assert (commit_wr_en == rec.wr_en)
                    else stop_run($sformatf("ERR %0t: commit_wr_en %0b, expected %0b",
                                            $time, commit_wr_en, rec.wr_en));
                if (rec.wr_en) begin
                    assert (commit_value == rec.value)
                        else stop_run($sformatf("ERR %0t: r%0d committed %h, expected %h",
                                                $time, rec.arn, commit_value, rec.value));
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > deadline) begin
                stop_run("timeout: commits stopped arriving before the tests finished");
            end
        end
    end

    task automatic test_idle_after_reset();
        repeat (10) begin
            @(negedge clock);
            assert (!structural_hazard)
                else stop_run($sformatf("ERR %0t: structural_hazard high while idle", $time));
            assert (!commit_valid)
                else stop_run($sformatf("ERR %0t: commit_valid high while idle", $time));
        end
    endtask

    task automatic test_alu_chains();
        for (int r = 1; r < ooo_pkg::arch_reg_sz; r++) begin
            send(ooo_pkg::op_li, r, 0, 0, 'h1000 * r + 'h35, 0);
        end
        send(ooo_pkg::op_add, 1, 1, 2, 0, 0);
        send(ooo_pkg::op_sub, 3, 1, 3, 0, 0);
        send(ooo_pkg::op_xor, 4, 3, 1, 0, 0);
        send(ooo_pkg::op_add, 5, 4, 4, 0, 0);
        send(ooo_pkg::op_sub, 6, 5, 1, 0, 0);
        send(ooo_pkg::op_xor, 7, 6, 7, 0, 0);
        send(ooo_pkg::op_add, 2, 7, 6, 0, 0);
        drain();
    endtask

    // the multiply broadcasts after the younger alu ops
    task automatic test_mult_overtaken();
        send(ooo_pkg::op_li, 1, 0, 0, 'h0123, 0);
        send(ooo_pkg::op_li, 3, 0, 0, 'h4567, 0);
        send(ooo_pkg::op_mul, 2, 1, 3, 0, 0);
        send(ooo_pkg::op_add, 4, 5, 6, 0, 0);
        send(ooo_pkg::op_xor, 7, 5, 6, 0, 0);
        send(ooo_pkg::op_sub, 6, 5, 1, 0, 0);
        send(ooo_pkg::op_add, 5, 4, 7, 0, 0);
        drain();
    endtask

    task automatic test_hazard_burst();
        hazard_holds = 0;
        send(ooo_pkg::op_li, 1, 0, 0, 3, 0);
        send(ooo_pkg::op_li, 2, 0, 0, 'h11, 0);
        for (int k = 0; k < 12; k++) begin
            send(ooo_pkg::op_mul, 1, 1, 2, 0, 1);
        end
        send(ooo_pkg::op_add, 3, 1, 2, 0, 1);
        drain();
        assert (hazard_holds > 0)
            else stop_run("structural_hazard never rose during the multiply burst");
    endtask

    task automatic test_zero_reg();
        send(ooo_pkg::op_li, 0, 0, 0, 'h1234, 0);
        send(ooo_pkg::op_add, 0, 1, 2, 0, 0);
        send(ooo_pkg::op_add, 3, 0, 1, 0, 0);
        send(ooo_pkg::op_xor, 4, 0, 2, 0, 0);
        send(ooo_pkg::op_mul, 0, 1, 2, 0, 0);
        send(ooo_pkg::op_sub, 5, 1, 0, 0, 0);
        drain();
    endtask

    task automatic test_random(input int count);
        ooo_pkg::opcode_t op;
        int dest;
        int src1;
        int src2;
        int imm;
        for (int k = 0; k < count; k++) begin
            op   = ooo_pkg::opcode_t'(take_bits(3) % 5);
            dest = int'(take_bits(3));
            src1 = int'(take_bits(3));
            src2 = int'(take_bits(3));
            imm  = int'(take_bits(16));
            send(op, dest, src1, src2, imm, 0);
        end
        drain();
    endtask

    initial begin
        lfsr_state     = lfsr_seed;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = ooo_pkg::op_li;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_imm   = '0;
        dispatch_count = 0;
        commit_count   = 0;
        hazard_holds   = 0;
        for (int r = 0; r < ooo_pkg::arch_reg_sz; r++) begin
            arch_regs[r] = '0;
        end
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_idle_after_reset();
        test_alu_chains();
        test_mult_overtaken();
        test_hazard_burst();
        test_zero_reg();
        test_random(200);

        if (commit_count == dispatch_count && expected.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_run($sformatf("ERR %0t: %0d commits for %0d dispatches",
                               $time, commit_count, dispatch_count));
        end
    end

endmodule

`default_nettype wire
